// ==== vector_glue_vectors.txt ====
// op_addr_data_exp: op 00 reset, 01 mem rd, 02 mem wr, 03 stack rd, 04 stack wr, 05 io wr,
// 06 io rd, 07 int ack, 08 joy rd (data = mode), 09 audio (addr: bit 8 psg on, 1..0 level)
00_0000_00_00
07_0038_5a_ff
01_1234_5a_00
03_0100_55_00
06_0020_00_ff
05_0010_25_00
01_a000_11_02
02_c123_00_02
01_8000_22_00
05_0010_fb_00
01_e000_66_04
04_8000_00_03
03_2000_55_03
01_8000_77_04
00_0000_00_00
01_a000_11_00
09_0001_00_00
08_0006_00_00
05_0005_20_00
08_0006_01_00
05_0004_0d_00
08_0006_03_00
05_0004_0a_00
08_0006_02_00
08_0007_00_00
08_000e_00_00
08_000f_00_00
05_0007_9c_00
09_0003_9c_00
09_0102_00_00
06_0001_c3_c3
06_000a_3c_33
06_0015_a5_55
06_0019_5e_a1
06_001d_5e_ff
06_000c_00_ff
06_0004_77_00
05_000c_12_01

// ==== flist.f ====
vector_bus_pkg.sv
bus_cycle_decode.sv
edisk_pager.sv
joy_port.sv
covox_audio_mix.sv
read_data_mux.sv
vector_glue_top.sv
vector_glue_checker.sv
tb_vector_glue.sv

// ==== tb_vector_glue.sv ====
// Testbench for the bus glue top; replays the vector file and checks read data, page and audio
`timescale 1ns/10ps

module tb_vector_glue;

	localparam int CLK_PERIOD     = 8;
	localparam int DRV_DLY        = 1;
	localparam int RST_CYCLES     = 4;
	localparam int MAX_VEC        = 64;
	localparam int CYC_PER_VEC    = 12;
	localparam int TIMEOUT_MARGIN = 50;
	localparam logic [31:0] SEED_INIT = 32'h8b32;

	// 8080 status bytes for each kind of machine cycle
	localparam logic [7:0] ST_MEM_RD = 8'h82;
	localparam logic [7:0] ST_MEM_WR = 8'h00;
	localparam logic [7:0] ST_STK_RD = 8'h86;
	localparam logic [7:0] ST_STK_WR = 8'h04;
	localparam logic [7:0] ST_IO_WR  = 8'h10;
	localparam logic [7:0] ST_IO_RD  = 8'h42;
	localparam logic [7:0] ST_INTA   = 8'h23;

	typedef enum logic [7:0] {
		OP_RESET,
		OP_MEM_RD,
		OP_MEM_WR,
		OP_STK_RD,
		OP_STK_WR,
		OP_IO_WR,
		OP_IO_RD,
		OP_INT_ACK,
		OP_JOY_RD,
		OP_AUDIO
	} vec_op_e;

	logic                              clk_sys;
	logic                              cold_reset;
	vector_bus_pkg::cpu_bus_t          cpu_bus;
	logic [vector_bus_pkg::DATA_W-1:0] ram_data;
	logic [vector_bus_pkg::DATA_W-1:0] ppi_data;
	logic [vector_bus_pkg::DATA_W-1:0] pit_data;
	logic [vector_bus_pkg::DATA_W-1:0] psg_data;
	logic [vector_bus_pkg::DATA_W-1:0] fdd_data;
	vector_bus_pkg::joy_pair_t         joy;
	vector_bus_pkg::psg_chan_t         psg;
	logic [1:0]                        legacy_level;
	logic [vector_bus_pkg::DATA_W-1:0] cpu_data;
	logic [vector_bus_pkg::PAGE_W-1:0] ram_page;
	logic                              pal_we;
	vector_bus_pkg::audio_pair_t       audio;

	logic [39:0] vec_mem [0:MAX_VEC-1];
	int          vec_count;
	int          timeout_limit = TIMEOUT_MARGIN;
	int          cycle_count = 0;
	int          pal_count = 0;
	int          seed = SEED_INIT;

	vector_glue_top dut_i (
		.clk_sys        (clk_sys),
		.cold_reset     (cold_reset),
		.cpu_bus_i      (cpu_bus),
		.ram_data_i     (ram_data),
		.ppi_data_i     (ppi_data),
		.pit_data_i     (pit_data),
		.psg_data_i     (psg_data),
		.fdd_data_i     (fdd_data),
		.joy_i          (joy),
		.psg_i          (psg),
		.legacy_level_i (legacy_level),
		.cpu_data_o     (cpu_data),
		.ram_page_o     (ram_page),
		.pal_we_o       (pal_we),
		.audio_o        (audio)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Cycle limit, palette strobe counter and bound assertion watch
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (pal_we) begin
			pal_count <= pal_count + 1;
		end
		if (dut_i.decode_i.assert_i.fail_cnt != 0) begin
			$display("A bus decode assertion failed");
			stop_run();
		end else if (cycle_count > timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("tests failed");
		$fatal(1, "run stopped on error");
	endtask

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_byte(input string name,
		input logic [vector_bus_pkg::DATA_W-1:0] got,
		input logic [vector_bus_pkg::DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_page(input string name,
		input logic [vector_bus_pkg::PAGE_W-1:0] got,
		input logic [vector_bus_pkg::PAGE_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_audio(input string name,
		input vector_bus_pkg::audio_pair_t got,
		input vector_bus_pkg::audio_pair_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// ----------------------------------------
	// Expected values
	// ----------------------------------------
	function automatic logic [7:0] expected_stick(input logic [7:0] btn);
		logic [7:0] v;
		v    = 8'h00;
		v[7] = btn[5];
		v[6] = btn[4];
		v[3] = btn[2];
		v[2] = btn[3];
		v[1] = btn[1];
		v[0] = btn[0];
		return ~v;
	endfunction

	function automatic logic [7:0] expected_pu(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] o;
		logic [7:0] v;
		o    = a | b;
		v    = 8'h00;
		v[7] = o[3];
		v[6] = o[0];
		v[5] = o[2];
		v[4] = o[1];
		v[3] = o[4];
		v[2] = o[5];
		return v;
	endfunction

	// Joystick read for a port; mode is register bits 6..5
	function automatic logic [7:0] expected_joy_read(input logic [7:0] port,
		input logic [1:0] mode);
		logic [7:0] a;
		logic [7:0] b;
		a = expected_stick(joy.joy_a);
		b = expected_stick(joy.joy_b);
		if (port == 8'h07) begin
			return expected_pu(joy.joy_a, joy.joy_b);
		end else if (port == 8'h0E) begin
			return a;
		end else if (port == 8'h0F) begin
			return b;
		end
		case (mode)
			2'd0: return a & b;
			2'd1: return a;
			2'd2: return b;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic vector_bus_pkg::audio_pair_t expected_mix(input logic [7:0] vox);
		vector_bus_pkg::audio_pair_t s;
		int l;
		int r;
		if (psg.active != 6'd0) begin
			l = 2 * psg.ch_a + psg.ch_b + 128 * legacy_level;
			r = 2 * psg.ch_c + psg.ch_b + 128 * legacy_level;
		end else begin
			l = 256 * legacy_level + 2 * vox;
			r = l;
		end
		s.left  = 16'(l << vector_bus_pkg::AUDIO_SHIFT);
		s.right = 16'(r << vector_bus_pkg::AUDIO_SHIFT);
		return s;
	endfunction

	// ----------------------------------------
	// Bus cycles
	// ----------------------------------------
	task automatic next_cycle();
		@(posedge clk_sys);
		#DRV_DLY;
	endtask

	task automatic apply_reset();
		cold_reset = 1'b1;
		repeat (RST_CYCLES) next_cycle();
		cold_reset = 1'b0;
	endtask

	// Status phase with sync high, then the data phase begins
	task automatic start_cycle(input logic [7:0] status, input logic [15:0] addr);
		cpu_bus.addr = addr;
		cpu_bus.dout = status;
		cpu_bus.sync = 1'b1;
		cpu_bus.dbin = 1'b0;
		cpu_bus.wr_n = 1'b1;
		next_cycle();
		cpu_bus.sync = 1'b0;
	endtask

	task automatic end_cycle();
		next_cycle();
		cpu_bus.dbin = 1'b0;
		cpu_bus.wr_n = 1'b1;
	endtask

	task automatic read_cycle(input logic [7:0] status, input logic [15:0] addr,
		input logic [7:0] exp_data, input logic [2:0] exp_page);
		start_cycle(status, addr);
		cpu_bus.dbin = 1'b1;
		@(negedge clk_sys);
		check_byte("cpu_data_o", cpu_data, exp_data);
		check_page("ram_page_o", ram_page, exp_page);
		end_cycle();
	endtask

	task automatic mem_write(input logic [7:0] status, input logic [15:0] addr,
		input logic [7:0] data, input logic [2:0] exp_page);
		start_cycle(status, addr);
		cpu_bus.dout = data;
		cpu_bus.wr_n = 1'b0;
		@(negedge clk_sys);
		check_page("ram_page_o", ram_page, exp_page);
		end_cycle();
	endtask

	// Register is visible two cycles after the write is first sampled
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] exp_pulses);
		pal_count = 0;
		start_cycle(ST_IO_WR, addr);
		cpu_bus.dout = data;
		cpu_bus.wr_n = 1'b0;
		repeat (2) next_cycle();
		cpu_bus.wr_n = 1'b1;
		@(negedge clk_sys);
		check_byte("pal_we_o pulses", 8'(pal_count), exp_pulses);
		next_cycle();
	endtask

	task automatic audio_check(input logic [15:0] addr, input logic [7:0] vox);
		legacy_level = addr[1:0];
		psg.ch_a     = 8'($random(seed));
		psg.ch_b     = 8'($random(seed));
		psg.ch_c     = 8'($random(seed));
		psg.active   = addr[8] ? (6'($random(seed)) | 6'd1) : 6'd0;
		@(negedge clk_sys);
		check_audio("audio_o", audio, expected_mix(vox));
		next_cycle();
	endtask

	initial begin
		vec_op_e     op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp_val;

		cold_reset   = 1'b1;
		cpu_bus      = '0;
		cpu_bus.wr_n = 1'b1;
		ram_data     = '0;
		ppi_data     = '0;
		pit_data     = '0;
		psg_data     = '0;
		fdd_data     = '0;
		joy          = '0;
		psg          = '0;
		legacy_level = '0;

		$readmemh("vector_glue_vectors.txt", vec_mem);
		vec_count = 0;
		while (vec_count < MAX_VEC && !$isunknown(vec_mem[vec_count])) begin
			vec_count++;
		end
		if (vec_count == 0) begin
			$display("No vectors were read from the vector file");
			stop_run();
		end
		timeout_limit = vec_count * CYC_PER_VEC + TIMEOUT_MARGIN;
		apply_reset();

		for (int i = 0; i < vec_count; i++) begin
			op      = vec_op_e'(vec_mem[i][39:32]);
			addr    = vec_mem[i][31:16];
			data    = vec_mem[i][15:8];
			exp_val = vec_mem[i][7:0];
			// Each peripheral gets a distinct byte so a wrong select shows up
			ram_data = data;
			ppi_data = data;
			pit_data = data ^ 8'h0F;
			psg_data = data ^ 8'hF0;
			fdd_data = ~data;
			case (op)
				OP_RESET: begin
					apply_reset();
					@(negedge clk_sys);
					check_page("ram_page_o", ram_page, exp_val[2:0]);
					next_cycle();
				end
				OP_MEM_RD:  read_cycle(ST_MEM_RD, addr, data, exp_val[2:0]);
				OP_MEM_WR:  mem_write(ST_MEM_WR, addr, data, exp_val[2:0]);
				OP_STK_RD:  read_cycle(ST_STK_RD, addr, data, exp_val[2:0]);
				OP_STK_WR:  mem_write(ST_STK_WR, addr, data, exp_val[2:0]);
				OP_IO_WR:   io_write(addr, data, exp_val);
				OP_IO_RD:   read_cycle(ST_IO_RD, addr, exp_val, 3'd0);
				OP_INT_ACK: read_cycle(ST_INTA, addr, exp_val, 3'd0);
				OP_JOY_RD: begin
					joy = 16'($random(seed));
					read_cycle(ST_IO_RD, addr, expected_joy_read(addr[7:0], data[1:0]), 3'd0);
				end
				OP_AUDIO:   audio_check(addr, data);
				default: begin
					$display("Unknown operation %h in vector %0d", vec_mem[i][39:32], i);
					stop_run();
				end
			endcase
		end

		repeat (2) next_cycle();
		if (dut_i.decode_i.assert_i.fail_cnt == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("Bus decode assertions failed %0d times", dut_i.decode_i.assert_i.fail_cnt);
			stop_run();
		end
	end

endmodule

// ==== vector_glue_checker.sv ====
// Bound assertions for bus_cycle_decode; checks write strobes and the status word latch
`timescale 1ns/10ps

module vector_glue_checker (
	input logic                              clk_sys,
	input logic                              cold_reset,
	input logic                              sync_i,
	input logic                              sync_q_i,
	input logic [vector_bus_pkg::DATA_W-1:0] status_i,
	input vector_bus_pkg::io_strobe_t        strobe_i
);

	// Count of failed assertions
	int fail_cnt = 0;

	// ----------------------------------------
	// Write strobes
	// ----------------------------------------
	strobe_single: assert property (@(posedge clk_sys) disable iff (cold_reset)
		(|strobe_i) |=> !(|strobe_i))
		else begin
			$error("write strobe held for more than one cycle");
			fail_cnt++;
		end

	strobe_onehot: assert property (@(posedge clk_sys) disable iff (cold_reset)
		$onehot0(strobe_i))
		else begin
			$error("more than one write strobe active");
			fail_cnt++;
		end

	strobe_reset: assert property (@(posedge clk_sys)
		cold_reset |=> (strobe_i == '0))
		else begin
			$error("write strobe active during reset");
			fail_cnt++;
		end

	// Status word moves only right after a sync rising edge
	status_hold: assert property (@(posedge clk_sys) disable iff (cold_reset)
		!$stable(status_i) |-> $past(sync_i && !sync_q_i))
		else begin
			$error("status word changed without a sync rise");
			fail_cnt++;
		end

endmodule

bind bus_cycle_decode vector_glue_checker assert_i (
	.clk_sys    (clk_sys),
	.cold_reset (cold_reset),
	.sync_i     (cpu_bus_i.sync),
	.sync_q_i   (sync_q),
	.status_i   (status_q),
	.strobe_i   (strobe_q)
);

// ==== vector_glue_top.sv ====
// Top of the bus glue; connects cycle decode, E-disk pager, joystick, audio and read mux
`timescale 1ns/10ps

module vector_glue_top (
	input  logic                              clk_sys,
	input  logic                              cold_reset,
	input  vector_bus_pkg::cpu_bus_t          cpu_bus_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] ram_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] ppi_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] pit_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] psg_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] fdd_data_i,
	input  vector_bus_pkg::joy_pair_t         joy_i,
	input  vector_bus_pkg::psg_chan_t         psg_i,
	input  logic [1:0]                        legacy_level_i,
	output logic [vector_bus_pkg::DATA_W-1:0] cpu_data_o,
	output logic [vector_bus_pkg::PAGE_W-1:0] ram_page_o,
	output logic                              pal_we_o,
	output vector_bus_pkg::audio_pair_t       audio_o
);

	vector_bus_pkg::bus_cycle_t        cycle;
	vector_bus_pkg::io_strobe_t        strobe;
	logic [vector_bus_pkg::DATA_W-1:0] joy_p;
	logic [vector_bus_pkg::DATA_W-1:0] joy_pu;
	logic [vector_bus_pkg::DATA_W-1:0] joy_a;
	logic [vector_bus_pkg::DATA_W-1:0] joy_b;

	bus_cycle_decode decode_i (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_bus_i  (cpu_bus_i),
		.cycle_o    (cycle),
		.strobe_o   (strobe)
	);

	edisk_pager edisk_i (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_bus_i  (cpu_bus_i),
		.cycle_i    (cycle),
		.edsk_we_i  (strobe.edsk_we),
		.page_o     (ram_page_o)
	);

	joy_port joy_i0 (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_bus_i  (cpu_bus_i),
		.joy_we_i   (strobe.joy_we),
		.joy_i      (joy_i),
		.joy_p_o    (joy_p),
		.joy_pu_o   (joy_pu),
		.joy_a_o    (joy_a),
		.joy_b_o    (joy_b)
	);

	covox_audio_mix audio_i (
		.clk_sys        (clk_sys),
		.cold_reset     (cold_reset),
		.cpu_bus_i      (cpu_bus_i),
		.vox_we_i       (strobe.vox_we),
		.psg_i          (psg_i),
		.legacy_level_i (legacy_level_i),
		.audio_o        (audio_o)
	);

	read_data_mux rdmux_i (
		.cycle_i    (cycle),
		.ram_data_i (ram_data_i),
		.ppi_data_i (ppi_data_i),
		.pit_data_i (pit_data_i),
		.psg_data_i (psg_data_i),
		.fdd_data_i (fdd_data_i),
		.joy_p_i    (joy_p),
		.joy_pu_i   (joy_pu),
		.joy_a_i    (joy_a),
		.joy_b_i    (joy_b),
		.cpu_data_o (cpu_data_o)
	);

	// Palette latch lives in the video block outside this design
	assign pal_we_o = strobe.pal_we;

endmodule

// ==== read_data_mux.sv ====
// CPU read data select: interrupt vector, I/O port bytes or RAM
`timescale 1ns/10ps

module read_data_mux (
	input  vector_bus_pkg::bus_cycle_t        cycle_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] ram_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] ppi_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] pit_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] psg_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] fdd_data_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] joy_p_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] joy_pu_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] joy_a_i,
	input  logic [vector_bus_pkg::DATA_W-1:0] joy_b_i,
	output logic [vector_bus_pkg::DATA_W-1:0] cpu_data_o
);

	logic [vector_bus_pkg::DATA_W-1:0] io_data;

	// Port 07 reads back the PU joystick, the covox itself is write only
	always_comb begin
		case (cycle_i.sel)
			vector_bus_pkg::SEL_PPI:     io_data = ppi_data_i;
			vector_bus_pkg::SEL_JOY_CTL: io_data = '0;
			vector_bus_pkg::SEL_JOY_P:   io_data = joy_p_i;
			vector_bus_pkg::SEL_VOX:     io_data = joy_pu_i;
			vector_bus_pkg::SEL_PIT:     io_data = pit_data_i;
			vector_bus_pkg::SEL_JOY_A:   io_data = joy_a_i;
			vector_bus_pkg::SEL_JOY_B:   io_data = joy_b_i;
			vector_bus_pkg::SEL_PSG:     io_data = psg_data_i;
			vector_bus_pkg::SEL_FDD:     io_data = cycle_i.fdd_ctl ? vector_bus_pkg::IO_IDLE_DATA
				: fdd_data_i;
			default:                     io_data = vector_bus_pkg::IO_IDLE_DATA;
		endcase
	end

	// Interrupt acknowledge reads RST 7 from the idle bus
	always_comb begin
		if (cycle_i.int_ack) begin
			cpu_data_o = vector_bus_pkg::IO_IDLE_DATA;
		end else if (cycle_i.io_read) begin
			cpu_data_o = io_data;
		end else begin
			cpu_data_o = ram_data_i;
		end
	end

endmodule

// ==== covox_audio_mix.sv ====
// Covox register and the stereo mixer for PSG channels, legacy beeper level and covox
`timescale 1ns/10ps

module covox_audio_mix (
	input  logic                              clk_sys,
	input  logic                              cold_reset,
	input  vector_bus_pkg::cpu_bus_t          cpu_bus_i,
	input  logic                              vox_we_i,
	input  vector_bus_pkg::psg_chan_t         psg_i,
	input  logic [1:0]                        legacy_level_i,
	output vector_bus_pkg::audio_pair_t       audio_o
);

	logic [vector_bus_pkg::DATA_W-1:0]      vox_q;
	logic                                   psg_on;
	logic [vector_bus_pkg::AUDIO_SUM_W-1:0] vox_sum;
	logic [vector_bus_pkg::AUDIO_SUM_W-1:0] sum_l;
	logic [vector_bus_pkg::AUDIO_SUM_W-1:0] sum_r;

	// Side channel doubled, centre channel B and legacy level shared
	function automatic logic [vector_bus_pkg::AUDIO_SUM_W-1:0] psg_sum(
		input logic [7:0] side,
		input logic [7:0] centre,
		input logic [1:0] level
	);
		return {2'b00, side, 1'b0} + {3'b000, centre} + {2'b00, level, 7'd0};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			vox_q <= vector_bus_pkg::VOX_RST;
		end else if (vox_we_i) begin
			vox_q <= cpu_bus_i.dout;
		end
	end

	assign psg_on  = |psg_i.active;
	assign vox_sum = {1'b0, legacy_level_i, 8'd0} + {2'b00, vox_q, 1'b0};

	assign sum_l = psg_on ? psg_sum(psg_i.ch_a, psg_i.ch_b, legacy_level_i) : vox_sum;
	assign sum_r = psg_on ? psg_sum(psg_i.ch_c, psg_i.ch_b, legacy_level_i) : vox_sum;

	assign audio_o.left  = {sum_l, {vector_bus_pkg::AUDIO_SHIFT{1'b0}}};
	assign audio_o.right = {sum_r, {vector_bus_pkg::AUDIO_SHIFT{1'b0}}};

endmodule

// ==== joy_port.sv ====
// Joystick port register and the read bytes built from the two button sets
`timescale 1ns/10ps

module joy_port (
	input  logic                              clk_sys,
	input  logic                              cold_reset,
	input  vector_bus_pkg::cpu_bus_t          cpu_bus_i,
	input  logic                              joy_we_i,
	input  vector_bus_pkg::joy_pair_t         joy_i,
	output logic [vector_bus_pkg::DATA_W-1:0] joy_p_o,
	output logic [vector_bus_pkg::DATA_W-1:0] joy_pu_o,
	output logic [vector_bus_pkg::DATA_W-1:0] joy_a_o,
	output logic [vector_bus_pkg::DATA_W-1:0] joy_b_o
);

	logic [vector_bus_pkg::DATA_W-1:0] joy_q;
	logic [vector_bus_pkg::DATA_W-1:0] joy_or;

	// Active-low button byte as seen on ports 0E/0F
	function automatic logic [vector_bus_pkg::DATA_W-1:0] stick_byte(
		input logic [vector_bus_pkg::DATA_W-1:0] btn
	);
		return ~{btn[5], btn[4], 2'b00, btn[2], btn[3], btn[1], btn[0]};
	endfunction

	// Odd address takes the whole byte, even address is a bit set/reset
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			joy_q <= vector_bus_pkg::JOY_RST;
		end else if (joy_we_i) begin
			if (cpu_bus_i.addr[0]) begin
				joy_q <= cpu_bus_i.dout;
			end else if (!cpu_bus_i.dout[7]) begin
				joy_q[cpu_bus_i.dout[3:1]] <= cpu_bus_i.dout[0];
			end
		end
	end

	assign joy_a_o = stick_byte(joy_i.joy_a);
	assign joy_b_o = stick_byte(joy_i.joy_b);

	// "PU" style joystick, both sticks merged, active high
	assign joy_or   = joy_i.joy_a | joy_i.joy_b;
	assign joy_pu_o = {joy_or[3], joy_or[0], joy_or[2], joy_or[1], joy_or[4], joy_or[5], 2'b00};

	always_comb begin
		case (joy_q[6:5])
			2'b00:   joy_p_o = joy_a_o & joy_b_o;
			2'b01:   joy_p_o = joy_a_o;
			2'b10:   joy_p_o = joy_b_o;
			default: joy_p_o = vector_bus_pkg::IO_IDLE_DATA;
		endcase
	end

endmodule

// ==== edisk_pager.sv ====
// E-disk control register; maps memory and stack accesses onto extra RAM pages
`timescale 1ns/10ps

module edisk_pager (
	input  logic                              clk_sys,
	input  logic                              cold_reset,
	input  vector_bus_pkg::cpu_bus_t          cpu_bus_i,
	input  vector_bus_pkg::bus_cycle_t        cycle_i,
	input  logic                              edsk_we_i,
	output logic [vector_bus_pkg::PAGE_W-1:0] page_o
);

	logic [vector_bus_pkg::DATA_W-1:0] ctl_q;
	logic                              a15;
	logic                              a14;
	logic                              a13;
	logic                              in_window;
	logic                              mem_access;
	logic                              stack_hit;
	logic                              window_hit;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ctl_q <= vector_bus_pkg::EDSK_RST;
		end else if (edsk_we_i) begin
			ctl_q <= cpu_bus_i.dout;
		end
	end

	assign a15 = cpu_bus_i.addr[15];
	assign a14 = cpu_bus_i.addr[14];
	assign a13 = cpu_bus_i.addr[13];

	// Window covers A000-DFFF always, E000-FFFF with bit 7, 8000-9FFF with bit 6
	assign in_window = a15 & ((a14 ^ a13) | (ctl_q[7] & a14 & a13) | (ctl_q[6] & ~a14 & ~a13));

	assign mem_access = cycle_i.ram_read | ~cycle_i.write_n;
	assign stack_hit  = ctl_q[4] & cycle_i.io_stack & mem_access;
	assign window_hit = ctl_q[5] & in_window & mem_access;

	// Stack mapping wins over the window
	always_comb begin
		if (stack_hit) begin
			page_o = {1'b0, ctl_q[3:2]} + 1'b1;
		end else if (window_hit) begin
			page_o = {1'b0, ctl_q[1:0]} + 1'b1;
		end else begin
			page_o = '0;
		end
	end

endmodule

// ==== bus_cycle_decode.sv ====
// Bus cycle front end: latches the 8080 status word, decodes I/O ports and forms write strobes
`timescale 1ns/10ps

module bus_cycle_decode (
	input  logic                       clk_sys,
	input  logic                       cold_reset,
	input  vector_bus_pkg::cpu_bus_t   cpu_bus_i,
	output vector_bus_pkg::bus_cycle_t cycle_o,
	output vector_bus_pkg::io_strobe_t strobe_o
);

	logic                              sync_q;
	logic [vector_bus_pkg::DATA_W-1:0] status_q;
	logic                              io_wr;
	logic                              io_wr_q;
	logic                              io_wr_rise;
	vector_bus_pkg::port_sel_e         sel;
	vector_bus_pkg::io_strobe_t        strobe_q;

	// ----------------------------------------
	// Status word, taken on the sync rising edge
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q   <= 1'b0;
			status_q <= vector_bus_pkg::STATUS_RST;
		end else begin
			sync_q <= cpu_bus_i.sync;
			if (cpu_bus_i.sync && !sync_q) begin
				status_q <= cpu_bus_i.dout;
			end
		end
	end

	// Port decode of the low address byte
	always_comb begin
		case (cpu_bus_i.addr[7:0]) inside
			[8'h00:8'h03]:              sel = vector_bus_pkg::SEL_PPI;
			[8'h04:8'h05]:              sel = vector_bus_pkg::SEL_JOY_CTL;
			vector_bus_pkg::PORT_JOY_P: sel = vector_bus_pkg::SEL_JOY_P;
			vector_bus_pkg::PORT_VOX:   sel = vector_bus_pkg::SEL_VOX;
			[8'h08:8'h0B]:              sel = vector_bus_pkg::SEL_PIT;
			[8'h0C:8'h0D]:              sel = vector_bus_pkg::SEL_PAL;
			vector_bus_pkg::PORT_JOY_A: sel = vector_bus_pkg::SEL_JOY_A;
			vector_bus_pkg::PORT_JOY_B: sel = vector_bus_pkg::SEL_JOY_B;
			vector_bus_pkg::PORT_EDSK:  sel = vector_bus_pkg::SEL_EDSK;
			[8'h14:8'h15]:              sel = vector_bus_pkg::SEL_PSG;
			[8'h18:8'h1F]:              sel = vector_bus_pkg::SEL_FDD;
			default:                    sel = vector_bus_pkg::SEL_NONE;
		endcase
	end

	// Status bits 3 (halt) and 5 (M1) have no user here
	assign cycle_o.int_ack  = status_q[0];
	assign cycle_o.write_n  = status_q[1];
	assign cycle_o.io_stack = status_q[2];
	assign cycle_o.io_write = status_q[4];
	assign cycle_o.io_read  = status_q[6];
	assign cycle_o.ram_read = status_q[7];
	assign cycle_o.mreq     = (status_q[7] | ~status_q[1]) & ~status_q[4] & ~status_q[6];
	assign cycle_o.sel      = sel;
	assign cycle_o.fdd_ctl  = (sel == vector_bus_pkg::SEL_FDD) & cpu_bus_i.addr[2];

	// ----------------------------------------
	// Write strobes, one cycle per I/O write
	// ----------------------------------------
	assign io_wr      = status_q[4] & ~cpu_bus_i.wr_n;
	assign io_wr_rise = io_wr & ~io_wr_q;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			io_wr_q  <= 1'b0;
			strobe_q <= '0;
		end else begin
			io_wr_q          <= io_wr;
			strobe_q.edsk_we <= io_wr_rise & (sel == vector_bus_pkg::SEL_EDSK);
			strobe_q.joy_we  <= io_wr_rise & (sel == vector_bus_pkg::SEL_JOY_CTL);
			strobe_q.vox_we  <= io_wr_rise & (sel == vector_bus_pkg::SEL_VOX);
			// Palette latch also sits behind the joystick read ports 0E/0F
			strobe_q.pal_we  <= io_wr_rise & ((sel == vector_bus_pkg::SEL_PAL) |
				(sel == vector_bus_pkg::SEL_JOY_A) | (sel == vector_bus_pkg::SEL_JOY_B));
		end
	end

	assign strobe_o = strobe_q;

endmodule

// ==== vector_bus_pkg.sv ====
// Shared widths, port addresses, reset values and bus structs for the Vector 06C bus glue
package vector_bus_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;
	localparam int PAGE_W      = 3;
	localparam int AUDIO_W     = 16;
	localparam int AUDIO_SHIFT = 5;
	// Mixer sum width before the zero padding
	localparam int AUDIO_SUM_W = AUDIO_W - AUDIO_SHIFT;

	// Byte seen on the data bus when nothing drives it
	localparam logic [DATA_W-1:0] IO_IDLE_DATA = 8'hFF;

	// Single-address ports
	localparam logic [7:0] PORT_JOY_P = 8'h06;
	localparam logic [7:0] PORT_VOX   = 8'h07;
	localparam logic [7:0] PORT_JOY_A = 8'h0E;
	localparam logic [7:0] PORT_JOY_B = 8'h0F;
	localparam logic [7:0] PORT_EDSK  = 8'h10;

	// Register values after cold reset
	localparam logic [DATA_W-1:0] STATUS_RST = 8'h00;
	localparam logic [DATA_W-1:0] EDSK_RST   = 8'h00;
	localparam logic [DATA_W-1:0] JOY_RST    = 8'h00;
	localparam logic [DATA_W-1:0] VOX_RST    = 8'h00;

	// ----------------------------------------
	// Device decoded from the low address byte
	// ----------------------------------------
	typedef enum logic [3:0] {
		SEL_NONE,
		SEL_PPI,
		SEL_JOY_CTL,
		SEL_JOY_P,
		SEL_VOX,
		SEL_PIT,
		SEL_PAL,
		SEL_JOY_A,
		SEL_JOY_B,
		SEL_EDSK,
		SEL_PSG,
		SEL_FDD
	} port_sel_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] dout;
		logic              sync;
		logic              dbin;
		logic              wr_n;
	} cpu_bus_t;

	typedef struct packed {
		logic      int_ack;
		logic      write_n;
		logic      io_stack;
		logic      io_write;
		logic      io_read;
		logic      ram_read;
		logic      mreq;
		port_sel_e sel;
		// FDD drive/side register at 1C..1F, no read data there
		logic      fdd_ctl;
	} bus_cycle_t;

	typedef struct packed {
		logic edsk_we;
		logic joy_we;
		logic vox_we;
		logic pal_we;
	} io_strobe_t;

	typedef struct packed {
		logic [DATA_W-1:0] joy_a;
		logic [DATA_W-1:0] joy_b;
	} joy_pair_t;

	typedef struct packed {
		logic [7:0] ch_a;
		logic [7:0] ch_b;
		logic [7:0] ch_c;
		logic [5:0] active;
	} psg_chan_t;

	typedef struct packed {
		logic [AUDIO_W-1:0] left;
		logic [AUDIO_W-1:0] right;
	} audio_pair_t;

endpackage
